// File: compile.f
logic/cpuBusPkg.sv
logic/chipBusPkg.sv
logic/regReqIf.sv
logic/phaseIf.sv
logic/cpuPort.sv
logic/phaseTracker.sv
logic/regCycleCtrl.sv
logic/laneSteer.sv
logic/regBridgeTop.sv
tests/regBridgeTb.sv

// File: Bender.yml
package:
  name: regBridge

sources:
  - logic/cpuBusPkg.sv
  - logic/chipBusPkg.sv
  - logic/regReqIf.sv
  - logic/phaseIf.sv
  - logic/cpuPort.sv
  - logic/phaseTracker.sv
  - logic/regCycleCtrl.sv
  - logic/laneSteer.sv
  - logic/regBridgeTop.sv
  - target: test
    files:
      - tests/regBridgeTb.sv

// File: tests/regBridgeVectors.txt
// REGSPACEn _ RnW _ SIZ0 _ A0 _ cpu write data _ chip read data _ DBRn hold cycles (hex)
// _ expected {UDSn,LDSn} when active (3 = none) _ expected chipDataOut _ expected cpuDataOut
0_1_0_0_0000_1234_00_0_0000_1234
0_0_0_0_BEEF_0000_00_0_BEEF_0000
0_0_1_0_12A5_0000_00_1_A5A5_0000
0_0_1_1_345A_0000_00_2_5A5A_0000
0_1_1_1_0000_C3C3_00_0_0000_C3C3
1_1_0_0_0000_FFFF_00_3_0000_0000
0_1_0_0_0000_5AA5_03_0_0000_5AA5
0_0_0_0_0F0F_0000_08_0_0F0F_0000
0_1_1_0_0000_8001_12_0_0000_8001
1_0_1_1_7777_0000_00_3_0000_0000
0_0_1_1_00C4_0000_01_2_C4C4_0000
0_1_0_0_0000_9669_14_0_0000_9669

// File: tests/regBridgeTb.sv
`timescale 1ns/10ps
`default_nettype none

module regBridgeTb;
    import cpuBusPkg::*;
    import chipBusPkg::*;

    localparam int COLOUR_PERIOD = 16;  // CLK80 cycles per colour clock
    localparam int RESET_CYCLES  = 5;
    localparam int VEC_MAX       = 64;

    logic                   CLK80 = 1'b0;
    logic                   RESETn, TSn, REGSPACEn, RnW, SIZ0, A0, C1, C3, DBRn;
    logic [CPU_DATA_W-1:0]  cpuDataIn, cpuDataOut;
    logic [CHIP_DATA_W-1:0] chipDataIn, chipDataOut;
    logic                   TACKn, ASn, UDSn, LDSn, REGENn, chipCycle;

    logic [95:0] vecMem [0:VEC_MAX-1];  // One access per entry
    logic [3:0]  colourCnt = '0;
    integer      seed = 32'hb0f4;
    int          errorCount = 0;
    int          checkCount = 0;
    int          cycleCount = 0;
    int          cycleLimit = 32'h7fff_ffff;  // Set once the vectors are known
    int          vecCount;
    int          maxHold;

    regBridgeTop #(.DATA_W(CPU_DATA_W), .CHIP_W(CHIP_DATA_W)) u_dut (.*);

    always #2 CLK80 = ~CLK80;

    // C3 high in quarters 0,1 and C1 high in quarters 3,0
    always @(posedge CLK80) begin
        colourCnt <= colourCnt + 4'd1;
        C3        <= ~colourCnt[3];
        C1        <= ~(colourCnt[3] ^ colourCnt[2]);
    end

    // Run length guard
    always @(posedge CLK80) begin
        cycleCount++;
        if (cycleCount >= cycleLimit) begin
            $display("Timeout after %0d cycles, the bridge never finished an access", cycleCount);
            $display("TEST FAILED");
            $finish;
        end
    end

    //////////////////////////////
    // Checks
    //////////////////////////////

    task automatic expectValue(input string name, input logic [31:0] got, input logic [31:0] exp);
        checkCount++;
        assert (got === exp) else begin
            errorCount++;
            $display("FAILED at %0t: %s = %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic requireTrue(input logic cond, input string what);
        checkCount++;
        assert (cond) else begin
            errorCount++;
            $display("Error at %0t: %s", $time, what);
        end
    endtask

    // Bus quiet while no request is open
    task automatic checkIdle();
        expectValue("REGENn", REGENn, 1);
        expectValue("ASn", ASn, 1);
        expectValue("UDSn", UDSn, 1);
        expectValue("LDSn", LDSn, 1);
        expectValue("TACKn", TACKn, 1);
        expectValue("chipCycle", chipCycle, 0);
    endtask

    //////////////////////////////
    // One access
    //////////////////////////////

    task automatic runAccess(input logic [95:0] vec);
        logic        space, rnw, a0, strobeSeen, regenSeen, chipSeen, dbrDone;
        accessSize_t size;
        logic [15:0] wdata, rdata, expWr, expRd;
        logic [1:0]  pair;
        int          hold, dbrLeft, tackLow, gap;
        space = vec[88];  // One hex digit per flag field
        rnw   = vec[84];
        size  = accessSize_t'(vec[80]);
        a0    = vec[76];
        wdata = vec[75:60];
        rdata = vec[59:44];
        hold  = vec[43:36];
        pair  = vec[33:32];
        expWr = vec[31:16];
        expRd = vec[15:0];
        strobeSeen = 1'b0;
        regenSeen  = 1'b0;
        chipSeen   = 1'b0;
        dbrDone    = 1'b0;
        dbrLeft    = 0;
        tackLow    = 0;
        gap = $unsigned($random(seed)) % 4;  // Stray idle cycles before TSn
        @(posedge CLK80);
        checkIdle();
        repeat (gap) begin
            @(posedge CLK80);
            checkIdle();
        end
        TSn       <= 1'b0;
        REGSPACEn <= space;
        RnW       <= rnw;
        SIZ0      <= size;
        A0        <= a0;
        cpuDataIn <= wdata;
        chipDataIn <= rdata;  // Held until the next access
        @(posedge CLK80);
        TSn <= 1'b1;
        if (space) begin
            // Bus stays quiet outside register space
            repeat (3 * COLOUR_PERIOD) begin
                @(posedge CLK80);
                checkIdle();
            end
        end else begin
            do begin
                @(posedge CLK80);
                if (!UDSn || !LDSn) begin
                    expectValue("ASn", ASn, 0);  // Data strobes only inside the address strobe
                end
                if ((!UDSn || !LDSn) && !strobeSeen) begin
                    strobeSeen = 1'b1;
                    expectValue("UDSn/LDSn", {UDSn, LDSn}, pair);
                    if (rnw) requireTrue(!REGENn, "read strobes fell before REGENn");
                    else requireTrue(regenSeen, "write strobes fell with or before REGENn");
                end
                if (!REGENn) regenSeen = 1'b1;
                if (chipCycle) chipSeen = 1'b1;
                if (!TACKn) tackLow++;
                if (dbrLeft > 0) begin
                    requireTrue(!chipCycle && TACKn, "chip cycle or TACKn active during DMA");
                    dbrLeft--;
                    if (dbrLeft == 0) DBRn <= 1'b1;
                end else if (!dbrDone && regenSeen && colourCnt == 4'd0 && hold > 0) begin
                    DBRn    <= 1'b0;  // Same edge as the C3 rise of state 4
                    dbrLeft = hold;
                    dbrDone = 1'b1;
                end
            end while (tackLow == 0 || !REGENn || !UDSn || !LDSn || !TACKn || dbrLeft > 0);
            expectValue("TACKn low cycles", tackLow, 1);
            requireTrue(chipSeen, "chipCycle never went high");
            requireTrue(strobeSeen, "no data strobe during the access");
            if (rnw) expectValue("cpuDataOut", cpuDataOut, expRd);
            else expectValue("chipDataOut", chipDataOut, expWr);
        end
    endtask

    //////////////////////////////
    // Main sequence
    //////////////////////////////

    initial begin
        RESETn     = 1'b0;
        TSn        = 1'b1;
        REGSPACEn  = 1'b1;
        RnW        = 1'b1;
        SIZ0       = 1'b0;
        A0         = 1'b0;
        cpuDataIn  = '0;
        chipDataIn = '0;
        C1         = 1'b1;
        C3         = 1'b1;
        DBRn       = 1'b1;
        // Top nibble F marks an unused entry
        for (int i = 0; i < VEC_MAX; i++) vecMem[i] = {4'hF, 92'(i)};
        $readmemh("tests/regBridgeVectors.txt", vecMem);
        vecCount = 0;
        maxHold  = 0;
        while (vecCount < VEC_MAX && vecMem[vecCount][95:92] != 4'hF) begin
            if (int'(vecMem[vecCount][43:36]) > maxHold) maxHold = vecMem[vecCount][43:36];
            vecCount++;
        end
        cycleLimit = vecCount * (4 * COLOUR_PERIOD + maxHold) + RESET_CYCLES;
        requireTrue(vecCount > 0, "no vectors read from the vector file");
        repeat (RESET_CYCLES) @(posedge CLK80);
        RESETn <= 1'b1;
        for (int v = 0; v < vecCount; v++) runAccess(vecMem[v]);
        @(posedge CLK80);
        $display("Vectors %0d, checks %0d, errors %0d", vecCount, checkCount, errorCount);
        if (errorCount == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: logic/regBridgeTop.sv
`timescale 1ns/10ps
`default_nettype none

module regBridgeTop #(
    parameter int DATA_W = cpuBusPkg::CPU_DATA_W,
    parameter int CHIP_W = chipBusPkg::CHIP_DATA_W
) (
    input  logic              CLK80,
    input  logic              RESETn,
    input  logic              TSn,
    input  logic              REGSPACEn,
    input  logic              RnW,
    input  logic              SIZ0,
    input  logic              A0,
    input  logic [DATA_W-1:0] cpuDataIn,
    input  logic              C1,
    input  logic              C3,
    input  logic              DBRn,
    input  logic [CHIP_W-1:0] chipDataIn,
    output logic [DATA_W-1:0] cpuDataOut,
    output logic [CHIP_W-1:0] chipDataOut,
    output logic              TACKn,
    output logic              ASn,
    output logic              UDSn,
    output logic              LDSn,
    output logic              REGENn,
    output logic              chipCycle
);

    logic strobeEn;
    logic laneLoad;
    logic latchRead;

    regReqIf #(.DATA_W(DATA_W)) reqBus ();
    phaseIf phBus ();

    assign ASn = REGENn;  // Chipset sees one address strobe

    cpuPort #(.DATA_W(DATA_W)) u_cpuPort (
        .CLK80, .RESETn, .TSn, .REGSPACEn, .RnW, .SIZ0, .A0,
        .cpuDataIn, .TACKn, .req(reqBus.port)
    );

    phaseTracker u_phaseTracker (
        .CLK80, .RESETn, .C1, .C3, .DBRn, .ph(phBus.tracker)
    );

    regCycleCtrl u_regCycleCtrl (
        .CLK80, .RESETn, .req(reqBus.ctrl), .ph(phBus.ctrl),
        .REGENn, .chipCycle, .strobeEn, .laneLoad, .latchRead
    );

    // Request fields stay put in the CPU port until the next TSn
    laneSteer #(.DATA_W(DATA_W), .CHIP_W(CHIP_W)) u_laneSteer (
        .CLK80, .RESETn, .laneLoad, .strobeEn, .latchRead,
        .rnw(reqBus.rnw), .size(reqBus.size), .a0(reqBus.a0), .wdata(reqBus.wdata),
        .chipDataIn, .chipDataOut, .cpuDataOut, .UDSn, .LDSn
    );

endmodule

`default_nettype wire

// File: logic/laneSteer.sv
`timescale 1ns/10ps
`default_nettype none

module laneSteer #(
    parameter int DATA_W = cpuBusPkg::CPU_DATA_W,
    parameter int CHIP_W = chipBusPkg::CHIP_DATA_W
) (
    input  logic                   CLK80,
    input  logic                   RESETn,
    input  logic                   laneLoad,
    input  logic                   strobeEn,
    input  logic                   latchRead,
    input  logic                   rnw,
    input  cpuBusPkg::accessSize_t size,
    input  logic                   a0,
    input  logic [DATA_W-1:0]      wdata,
    input  logic [CHIP_W-1:0]      chipDataIn,
    output logic [CHIP_W-1:0]      chipDataOut,
    output logic [DATA_W-1:0]      cpuDataOut,
    output logic                   UDSn,
    output logic                   LDSn
);
    import cpuBusPkg::*;

    laneMask_t maskNew;
    laneMask_t maskQ;
    laneMask_t maskUse;

    // Even address is the upper lane on the 68000 bus
    always_comb begin
        maskNew.upper = rnw || (size == sizeWord) || !a0;
        maskNew.lower = rnw || (size == sizeWord) || a0;
        maskUse       = laneLoad ? maskNew : maskQ;  // Same edge as REGENn
    end

    always_ff @(negedge CLK80) begin
        if (!RESETn) begin
            maskQ <= '0;
            UDSn  <= 1'b1;
            LDSn  <= 1'b1;
        end else begin
            if (laneLoad) begin
                maskQ <= maskNew;
            end
            UDSn <= ~(maskUse.upper & strobeEn);
            LDSn <= ~(maskUse.lower & strobeEn);
        end
    end

    //////////////////////////////
    // Data paths
    //////////////////////////////

    always_ff @(negedge CLK80) begin
        if (laneLoad && !rnw) begin
            if (size == sizeByte) begin
                chipDataOut <= {(CHIP_W / 8){wdata[7:0]}};  // Byte on every lane
            end else begin
                chipDataOut <= CHIP_W'(wdata);
            end
        end
        if (latchRead) begin
            cpuDataOut <= DATA_W'(chipDataIn);  // Held for the CPU past TACKn
        end
    end

endmodule

`default_nettype wire

// File: logic/regCycleCtrl.sv
`timescale 1ns/10ps
`default_nettype none

module regCycleCtrl (
    input  logic  CLK80,
    input  logic  RESETn,
    regReqIf.ctrl req,
    phaseIf.ctrl  ph,
    output logic  REGENn,
    output logic  chipCycle,
    output logic  strobeEn,   // Strobe level for the next cycle
    output logic  laneLoad,   // Capture lane mask and write data
    output logic  latchRead   // Capture chip read data
);
    import chipBusPkg::*;

    busState_t state;
    busState_t stateNext;
    logic      readyQ;
    logic      rnwQ;      // Direction of the access in flight
    logic      accept;
    logic      addrPhase; // Next state still before the address strobe

    assign accept = req.valid && readyQ;

    //////////////////////////////
    // Next state
    //////////////////////////////

    always_comb begin
        stateNext = state;
        unique case (state)
            idle: begin
                if (accept) stateNext = s2Wait;
            end
            s2Wait: begin
                if (ph.s2Edge) stateNext = s4Wait;  // Address strobe goes out
            end
            s4Wait: begin
                if (ph.s4Edge) stateNext = dbrWait;  // Write strobes go out
            end
            dbrWait: begin
                // Wait states until Agnus releases the bus in state 4
                if (ph.s4Hold && ph.dbrFree) stateNext = s5Wait;
            end
            s5Wait: begin
                if (ph.s5Edge) stateNext = s6Wait;
            end
            s6Wait: begin
                if (ph.s6Edge) stateNext = s7Wait;
            end
            s7Wait: begin
                if (ph.s7Edge) stateNext = idle;  // Bus released
            end
            default: stateNext = idle;
        endcase
    end

    assign addrPhase = (stateNext == idle) || (stateNext == s2Wait);

    // Reads open the strobes with REGENn, writes wait for state 4
    always_comb begin
        if (rnwQ) begin
            strobeEn = !addrPhase;
        end else begin
            strobeEn = !addrPhase && (stateNext != s4Wait);
        end
    end

    assign laneLoad  = (state == s2Wait) && ph.s2Edge;
    assign latchRead = (state == s5Wait) && ph.s5Edge && rnwQ;  // Early latch in state 5

    // Reads end at state 5, writes at state 6
    assign req.done  = latchRead || ((state == s6Wait) && ph.s6Edge && !rnwQ);
    assign req.ready = readyQ;

    //////////////////////////////
    // State and bus outputs
    //////////////////////////////

    always_ff @(negedge CLK80) begin
        if (!RESETn) begin
            state     <= idle;
            readyQ    <= 1'b0;
            rnwQ      <= 1'b1;
            REGENn    <= 1'b1;
            chipCycle <= 1'b0;
        end else begin
            state  <= stateNext;
            readyQ <= (stateNext == idle);  // Low again once a request is taken
            REGENn <= addrPhase;
            if (accept) begin
                rnwQ <= req.rnw;
            end
            // High after the DMA wait, through the cycle after state 5
            chipCycle <= (stateNext == s5Wait) || (state == s5Wait);
        end
    end

endmodule

`default_nettype wire

// File: logic/phaseTracker.sv
`timescale 1ns/10ps
`default_nettype none

module phaseTracker (
    input  logic     CLK80,
    input  logic     RESETn,
    input  logic     C1,
    input  logic     C3,
    input  logic     DBRn,
    phaseIf.tracker  ph
);
    import chipBusPkg::*;

    logic [SYNC_LEN-1:0]     c1Sync;
    logic [SYNC_LEN-1:0]     c3Sync;
    logic [DBR_SYNC_LEN-1:0] dbrSync;
    logic [4:0]              hit;   // Pattern match per edge, s2 s4 s5 s6 s7
    logic [4:0]              hitQ;  // Previous match

    //////////////////////////////
    // Synchronizers
    //////////////////////////////

    always_ff @(negedge CLK80) begin
        if (!RESETn) begin
            c1Sync  <= '1;  // Preset high like the idle chip clocks
            c3Sync  <= '1;
            dbrSync <= '1;
            hitQ    <= '0;
        end else begin
            c1Sync  <= {c1Sync[SYNC_LEN-2:0], C1};
            c3Sync  <= {c3Sync[SYNC_LEN-2:0], C3};
            dbrSync <= {dbrSync[DBR_SYNC_LEN-2:0], DBRn};
            hitQ    <= hit;
        end
    end

    //////////////////////////////
    // Edge decode
    //////////////////////////////

    always_comb begin
        hit[0] = (c1Sync == C1_S2) && (c3Sync == C3_S2);
        hit[1] = (c1Sync == C1_S4) && (c3Sync == C3_S4);
        hit[2] = (c1Sync == C1_S5) && (c3Sync == C3_S5);
        hit[3] = (c1Sync == C1_S6) && (c3Sync == C3_S6);  // Level, edge taken below
        hit[4] = (c1Sync == C1_S7) && (c3Sync == C3_S7);
    end

    // First cycle of each match only
    assign ph.s2Edge = hit[0] & ~hitQ[0];
    assign ph.s4Edge = hit[1] & ~hitQ[1];
    assign ph.s5Edge = hit[2] & ~hitQ[2];
    assign ph.s6Edge = hit[3] & ~hitQ[3];
    assign ph.s7Edge = hit[4] & ~hitQ[4];

    assign ph.s4Hold  = (c1Sync == C1_HOLD) && (c3Sync == C3_HOLD);
    assign ph.dbrFree = &dbrSync;  // DBRn seen high on every stage

endmodule

`default_nettype wire

// File: logic/cpuPort.sv
`timescale 1ns/10ps
`default_nettype none

module cpuPort #(
    parameter int DATA_W = cpuBusPkg::CPU_DATA_W
) (
    input  logic              CLK80,
    input  logic              RESETn,
    input  logic              TSn,
    input  logic              REGSPACEn,
    input  logic              RnW,
    input  logic              SIZ0,
    input  logic              A0,
    input  logic [DATA_W-1:0] cpuDataIn,
    output logic              TACKn,
    regReqIf.port             req
);
    import cpuBusPkg::*;

    logic              validQ;
    logic              rnwQ;
    accessSize_t       sizeQ;
    logic              a0Q;
    logic [DATA_W-1:0] wdataQ;
    logic              tsHit;

    // Start of a register space transfer, only one may be open
    assign tsHit = !TSn && !REGSPACEn && !validQ;

    //////////////////////////////
    // Request flag and acknowledge
    //////////////////////////////

    always_ff @(negedge CLK80) begin
        if (!RESETn) begin
            validQ <= 1'b0;
            TACKn  <= 1'b1;
        end else begin
            if (tsHit) begin
                validQ <= 1'b1;       // Held until the controller is idle
            end else if (validQ && req.ready) begin
                validQ <= 1'b0;       // Handshake taken
            end
            TACKn <= ~req.done;       // One cycle low per done pulse
        end
    end

    // Transfer attributes, stable until the next TSn
    always_ff @(negedge CLK80) begin
        if (tsHit) begin
            rnwQ   <= RnW;
            sizeQ  <= accessSize_t'(SIZ0);
            a0Q    <= A0;
            wdataQ <= cpuDataIn;  // Only meaningful on writes
        end
    end

    assign req.valid = validQ;
    assign req.rnw   = rnwQ;
    assign req.size  = sizeQ;
    assign req.a0    = a0Q;
    assign req.wdata = wdataQ;

endmodule

`default_nettype wire

// File: logic/phaseIf.sv
`timescale 1ns/10ps
`default_nettype none

// Decoded colour clock events, no handshake
interface phaseIf ();

    logic s2Edge;   // Pulses, one CLK80 cycle each
    logic s4Edge;
    logic s5Edge;
    logic s6Edge;
    logic s7Edge;
    logic s4Hold;   // Level, late state 4 window
    logic dbrFree;  // Level, no DMA request

    modport tracker (output s2Edge, s4Edge, s5Edge, s6Edge, s7Edge, s4Hold, dbrFree);
    modport ctrl (input s2Edge, s4Edge, s5Edge, s6Edge, s7Edge, s4Hold, dbrFree);

endinterface

`default_nettype wire

// File: logic/regReqIf.sv
`timescale 1ns/10ps
`default_nettype none

// One register access handed from the CPU port to the cycle controller
interface regReqIf #(
    parameter int DATA_W = cpuBusPkg::CPU_DATA_W
) ();
    import cpuBusPkg::*;

    logic              valid;  // Request pending
    logic              ready;  // Controller idle
    logic              done;   // CPU cycle may end, one cycle wide
    logic              rnw;
    accessSize_t       size;
    logic              a0;
    logic [DATA_W-1:0] wdata;

    modport port (output valid, rnw, size, a0, wdata, input ready, done);
    modport ctrl (input valid, rnw, size, a0, wdata, output ready, done);

endinterface

`default_nettype wire

// File: logic/chipBusPkg.sv
`default_nettype none

//////////////////////////////
// Chipset side of the bridge
//////////////////////////////

package chipBusPkg;

    parameter int CHIP_DATA_W  = 16;  // Custom chip data bus
    parameter int SYNC_LEN     = 3;   // C1 / C3 sampler depth
    parameter int DBR_SYNC_LEN = 2;   // DBRn sampler depth

    // MC68000 bus cycle as seen from the bridge
    typedef enum logic [2:0] {
        idle    = 3'd0,
        s2Wait  = 3'd1,  // Waiting for the state 2 edge
        s4Wait  = 3'd2,  // Waiting for the state 4 edge
        dbrWait = 3'd3,  // Wait states while DMA owns the bus
        s5Wait  = 3'd4,
        s6Wait  = 3'd5,
        s7Wait  = 3'd6
    } busState_t;

    // Sampled history, bit 0 is the newest sample
    parameter logic [SYNC_LEN-1:0] C1_S2   = 3'b000, C3_S2   = 3'b110;  // C3 falls, C1 low
    parameter logic [SYNC_LEN-1:0] C1_S4   = 3'b111, C3_S4   = 3'b001;  // C3 rises, C1 high
    parameter logic [SYNC_LEN-1:0] C1_HOLD = 3'b111, C3_HOLD = 3'b111;  // Both settled high
    parameter logic [SYNC_LEN-1:0] C1_S5   = 3'b110, C3_S5   = 3'b111;  // C1 falls, C3 high
    parameter logic [SYNC_LEN-1:0] C1_S6   = 3'b000, C3_S6   = 3'b000;  // Both low
    parameter logic [SYNC_LEN-1:0] C1_S7   = 3'b011, C3_S7   = 3'b000;  // C1 rose, C3 low

endpackage

`default_nettype wire

// File: logic/cpuBusPkg.sv
`default_nettype none

//////////////////////////////
// CPU side of the bridge
//////////////////////////////

package cpuBusPkg;

    // Width of the CPU data path seen by the bridge
    parameter int CPU_DATA_W = 16;

    // Transfer size as decoded from SIZ0 alone
    // Long and line sizes never reach register space
    typedef enum logic {
        sizeWord = 1'b0,  // SIZ0 low
        sizeByte = 1'b1   // SIZ0 high
    } accessSize_t;

    // Strobe request per byte lane
    typedef struct packed {
        logic upper;  // D15..D8, drives UDSn
        logic lower;  // D7..D0, drives LDSn
    } laneMask_t;

endpackage

`default_nettype wire
